// ==== design/ooo_pkg.sv ====
/*
 * Shared sizes, ALU operation codes and packed records of the
 * out-of-order core
 */
`default_nettype none

package ooo_pkg;

    //////////////////////////////////////////////////////////////////////
    // Machine sizes
    localparam int DATA_W    = 16;
    localparam int ARCH_REGS = 8;
    localparam int PHYS_REGS = 16;
    localparam int ROB_DEPTH = 8;

    // Register, tag and slot indices
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_tag_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
    typedef logic [DATA_W-1:0]            data_t;

    // ALU operations
    // LI loads imm into rd and ignores both sources
    typedef enum logic [1:0] {
        ADD = 2'd0,
        SUB = 2'd1,
        XOR = 2'd2,
        LI  = 2'd3
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // Records passed between blocks

    // Instruction from the outside sender
    typedef struct packed {
        alu_op_e   op;
        arch_idx_t rd;
        arch_idx_t rs1;
        arch_idx_t rs2;
        data_t     imm;
    } instr_t;

    // Operation handed to the ALU with operand values already read
    typedef struct packed {
        alu_op_e   op;
        data_t     opa;
        data_t     opb;
        data_t     imm;
        phys_tag_t tag;
        rob_idx_t  rob;
    } issue_t;

    // Result broadcast
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
        rob_idx_t  rob;
        data_t     result;
    } wb_t;

    // ROB slot contents
    // old_tag goes back to the free list at retirement
    typedef struct packed {
        arch_idx_t rd;
        phys_tag_t new_tag;
        phys_tag_t old_tag;
    } rob_entry_t;

    // Retired instruction as seen from outside
    typedef struct packed {
        logic      valid;
        arch_idx_t rd;
        data_t     value;
    } commit_t;

endpackage

`default_nettype wire

// ==== design/ring_queue.sv ====
/*
 * Circular FIFO with a type parameter for its payload
 * Head entry is readable without popping
 */
`timescale 1ns/1ps
`default_nettype none

module ring_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4,
    localparam int IDX_W     = $clog2(DEPTH),
    localparam int CNT_W     = $clog2(DEPTH + 1)
) (
    input  logic             clock,
    input  logic             rst,
    input  logic             push,
    input  payload_t         push_data,
    input  logic             pop,
    output payload_t         head_data,
    output logic             empty,
    output logic             full,
    output logic [IDX_W-1:0] head_idx,
    output logic [IDX_W-1:0] tail_idx
);

    payload_t         mem [DEPTH];
    logic [IDX_W-1:0] rd_ptr;
    logic [IDX_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // Pointer advance with wrap for any depth
    function automatic logic [IDX_W-1:0] bump(input logic [IDX_W-1:0] ptr);
        return (ptr == IDX_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clock) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= bump(wr_ptr);
            if (pop) rd_ptr <= bump(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    assign head_data = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign head_idx  = rd_ptr;
    assign tail_idx  = wr_ptr;

    // Callers must respect full and empty
    a_no_overflow: assert property (@(posedge clock) disable iff (rst) push |-> !full);
    a_no_underflow: assert property (@(posedge clock) disable iff (rst) pop |-> !empty);

endmodule

`default_nettype wire

// ==== design/rename_table.sv ====
/*
 * Speculative map from architectural to physical registers
 * Busy bit per physical register tracks pending results
 */
`timescale 1ns/1ps
`default_nettype none

module rename_table
    import ooo_pkg::*;
(
    input  logic            clock,
    input  logic            rst,
    input  arch_idx_t [1:0] src_idx,
    input  logic            map_we,
    input  arch_idx_t       map_rd,
    input  phys_tag_t       map_tag,
    input  wb_t             wb,
    output phys_tag_t [1:0] src_tag,
    output logic      [1:0] src_ready,
    output phys_tag_t       old_tag
);

    phys_tag_t              map [ARCH_REGS];
    logic [PHYS_REGS-1:0]   busy;

    always_ff @(posedge clock) begin
        if (rst) begin
            // Identity mapping, nothing pending
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= phys_tag_t'(i);
            end
            busy <= '0;
        end else begin
            if (map_we) map[map_rd] <= map_tag;
            // Writeback first, so a new rename wins
            if (wb.valid) busy[wb.tag] <= 1'b0;
            if (map_we) busy[map_tag] <= 1'b1;
        end
    end

    // Source tags and readiness
    // Same-cycle writeback counts as ready
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_tag[s]   = map[src_idx[s]];
            src_ready[s] = !busy[src_tag[s]] || (wb.valid && (wb.tag == src_tag[s]));
        end
    end

    // Mapping being replaced
    assign old_tag = map[map_rd];

endmodule

`default_nettype wire

// ==== design/free_list.sv ====
/*
 * Bitmap allocator of free physical registers
 * Hands out the lowest free tag
 */
`timescale 1ns/1ps
`default_nettype none

module free_list
    import ooo_pkg::*;
(
    input  logic      clock,
    input  logic      rst,
    input  logic      alloc,
    input  logic      free_valid,
    input  phys_tag_t free_tag,
    output logic      avail,
    output phys_tag_t alloc_tag
);

    logic [PHYS_REGS-1:0] free_map;

    always_ff @(posedge clock) begin
        if (rst) begin
            // Tags below ARCH_REGS hold the reset mapping
            for (int i = 0; i < PHYS_REGS; i++) begin
                free_map[i] <= (i >= ARCH_REGS);
            end
        end else begin
            if (alloc) free_map[alloc_tag] <= 1'b0;
            if (free_valid) free_map[free_tag] <= 1'b1;
        end
    end

    // Lowest set bit
    always_comb begin
        alloc_tag = '0;
        for (int i = PHYS_REGS - 1; i >= 0; i--) begin
            if (free_map[i]) alloc_tag = phys_tag_t'(i);
        end
    end

    assign avail = |free_map;

    // Retirement must not release a tag twice
    a_double_free: assert property (@(posedge clock) disable iff (rst)
        free_valid |-> !free_map[free_tag]);

endmodule

`default_nettype wire

// ==== design/reorder_buffer.sv ====
/*
 * Reorder buffer: tracks completion per slot and retires in order,
 * one per cycle, releasing the old tag and reporting a commit record
 */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
    import ooo_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  logic       push,
    input  rob_entry_t entry,
    input  wb_t        wb,
    output logic       full,
    output rob_idx_t   slot,
    output logic       free_valid,
    output phys_tag_t  free_tag,
    output commit_t    commit
);

    rob_entry_t           head_entry;
    rob_idx_t             head_idx;
    logic                 empty;
    logic                 retire;
    logic [ROB_DEPTH-1:0] done;
    data_t                value [ROB_DEPTH];

    // Entry storage in program order
    ring_queue #(
        .payload_t(rob_entry_t),
        .DEPTH    (ROB_DEPTH)
    ) rob_q_0 (
        .clock    (clock),
        .rst      (rst),
        .push     (push),
        .push_data(entry),
        .pop      (retire),
        .head_data(head_entry),
        .empty    (empty),
        .full     (full),
        .head_idx (head_idx),
        .tail_idx (slot)
    );

    // Completion bits
    always_ff @(posedge clock) begin
        if (rst) begin
            done <= '0;
        end else begin
            if (push) done[slot] <= 1'b0;
            if (wb.valid) done[wb.rob] <= 1'b1;
        end
    end

    // Result values
    always_ff @(posedge clock) begin
        if (wb.valid) value[wb.rob] <= wb.result;
    end

    // Head retires once complete
    assign retire     = !empty && done[head_idx];
    assign free_valid = retire;
    assign free_tag   = head_entry.old_tag;

    // Registered commit record
    always_ff @(posedge clock) begin
        if (retire) begin
            commit.rd    <= head_entry.rd;
            commit.value <= value[head_idx];
        end
        if (rst) begin
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= retire;
        end
    end

endmodule

`default_nettype wire

// ==== design/phys_regfile.sv ====
/*
 * Physical register file, two read ports and one write port
 * Reads see a same-cycle write
 */
`timescale 1ns/1ps
`default_nettype none

module phys_regfile
    import ooo_pkg::*;
(
    input  logic            clock,
    input  logic            rst,
    input  phys_tag_t [1:0] rd_tag,
    input  wb_t             wb,
    output data_t     [1:0] rd_data
);

    data_t regs [PHYS_REGS];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.tag] <= wb.result;
        end
    end

    // Write-through bypass
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rd_data[p] = (wb.valid && (wb.tag == rd_tag[p])) ? wb.result : regs[rd_tag[p]];
        end
    end

endmodule

`default_nettype wire

// ==== design/alu_pipe.sv ====
/*
 * Two-stage ALU: operation latched, computed, then registered
 * as a writeback two cycles after issue
 */
`timescale 1ns/1ps
`default_nettype none

module alu_pipe
    import ooo_pkg::*;
(
    input  logic   clock,
    input  logic   rst,
    input  logic   issue_valid,
    input  issue_t issue,
    output wb_t    wb
);

    issue_t s1;
    logic   s1_valid;
    data_t  result;

    // Stage 1 operation register
    always_ff @(posedge clock) begin
        s1 <= issue;
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
    end

    always_comb begin
        case (s1.op)
            ADD:     result = s1.opa + s1.opb;
            SUB:     result = s1.opa - s1.opb;
            XOR:     result = s1.opa ^ s1.opb;
            default: result = s1.imm;
        endcase
    end

    // Stage 2 writeback register
    always_ff @(posedge clock) begin
        wb.tag    <= s1.tag;
        wb.rob    <= s1.rob;
        wb.result <= result;
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= s1_valid;
        end
    end

endmodule

`default_nettype wire

// ==== design/dispatch_ctrl.sv ====
/*
 * Dispatch control: buffers incoming instructions, renames the head,
 * allocates a tag and a ROB slot, issues to the ALU, returns credits
 */
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl
    import ooo_pkg::*;
#(
    parameter int IQ_DEPTH = 4
) (
    input  logic            clock,
    input  logic            rst,
    // Credit-based instruction input
    input  logic            in_valid,
    input  instr_t          in_instr,
    output logic            credit_return,
    // Rename table lookup and update
    output arch_idx_t [1:0] src_idx,
    input  phys_tag_t [1:0] src_tag,
    input  logic      [1:0] src_ready,
    output logic            map_we,
    output arch_idx_t       map_rd,
    output phys_tag_t       map_tag,
    input  phys_tag_t       old_tag,
    // Free list
    output logic            fl_alloc,
    input  logic            fl_avail,
    input  phys_tag_t       fl_tag,
    // Reorder buffer
    output logic            rob_push,
    output rob_entry_t      rob_entry,
    input  logic            rob_full,
    input  rob_idx_t        rob_slot,
    // Operand reads
    output phys_tag_t [1:0] rd_tag,
    input  data_t     [1:0] rd_data,
    // ALU issue
    output logic            issue_valid,
    output issue_t          issue
);

    instr_t head;
    logic   iq_empty;
    logic   iq_full;
    logic   dispatch;

    //////////////////////////////////////////////////////////////////////
    // Instruction buffer
    ring_queue #(
        .payload_t(instr_t),
        .DEPTH    (IQ_DEPTH)
    ) iq_0 (
        .clock    (clock),
        .rst      (rst),
        .push     (in_valid),
        .push_data(in_instr),
        .pop      (dispatch),
        .head_data(head),
        .empty    (iq_empty),
        .full     (iq_full),
        .head_idx (),
        .tail_idx ()
    );

    // Source lookup for the head
    assign src_idx[0] = head.rs1;
    assign src_idx[1] = head.rs2;
    // Register file reads the renamed sources
    assign rd_tag     = src_tag;

    //////////////////////////////////////////////////////////////////////
    // Dispatch decision
    // Head waits for sources, a free tag and a ROB slot
    assign dispatch      = !iq_empty && (&src_ready) && fl_avail && !rob_full;
    // One credit back per popped entry
    assign credit_return = dispatch;

    // Rename rd onto the new tag
    assign map_we   = dispatch;
    assign map_rd   = head.rd;
    assign map_tag  = fl_tag;
    assign fl_alloc = dispatch;

    // ROB keeps the previous mapping for release at retirement
    assign rob_push  = dispatch;
    assign rob_entry = '{rd: head.rd, new_tag: fl_tag, old_tag: old_tag};

    // Issue in the same cycle with operand values
    assign issue_valid = dispatch;
    assign issue = '{
        op:  head.op,
        opa: rd_data[0],
        opb: rd_data[1],
        imm: head.imm,
        tag: fl_tag,
        rob: rob_slot
    };

    // Sender may only send while it holds a credit
    a_credit_overrun: assert property (@(posedge clock) disable iff (rst)
        in_valid |-> !iq_full);

endmodule

`default_nettype wire

// ==== design/ooo_core.sv ====
/*
 * Out-of-order core top: rename, in-order issue to a two-stage ALU,
 * in-order retirement through the reorder buffer
 */
`timescale 1ns/1ps
`default_nettype none

module ooo_core
    import ooo_pkg::*;
#(
    parameter int IQ_DEPTH = 4
) (
    input  logic    clock,
    input  logic    rst,
    input  logic    in_valid,
    input  instr_t  in_instr,
    output logic    credit_return,
    output commit_t commit
);

    //////////////////////////////////////////////////////////////////////
    // Interconnect
    arch_idx_t [1:0] src_idx;
    phys_tag_t [1:0] src_tag;
    logic      [1:0] src_ready;
    logic            map_we;
    arch_idx_t       map_rd;
    phys_tag_t       map_tag;
    phys_tag_t       old_tag;
    logic            fl_alloc;
    logic            fl_avail;
    phys_tag_t       fl_tag;
    logic            rob_push;
    rob_entry_t      rob_entry;
    logic            rob_full;
    rob_idx_t        rob_slot;
    phys_tag_t [1:0] rd_tag;
    data_t     [1:0] rd_data;
    logic            issue_valid;
    issue_t          issue;
    // Shared result broadcast
    wb_t             wb;
    logic            free_valid;
    phys_tag_t       free_tag;

    //////////////////////////////////////////////////////////////////////
    // Front end
    dispatch_ctrl #(
        .IQ_DEPTH(IQ_DEPTH)
    ) dispatch_ctrl_0 (
        .clock        (clock),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .credit_return(credit_return),
        .src_idx      (src_idx),
        .src_tag      (src_tag),
        .src_ready    (src_ready),
        .map_we       (map_we),
        .map_rd       (map_rd),
        .map_tag      (map_tag),
        .old_tag      (old_tag),
        .fl_alloc     (fl_alloc),
        .fl_avail     (fl_avail),
        .fl_tag       (fl_tag),
        .rob_push     (rob_push),
        .rob_entry    (rob_entry),
        .rob_full     (rob_full),
        .rob_slot     (rob_slot),
        .rd_tag       (rd_tag),
        .rd_data      (rd_data),
        .issue_valid  (issue_valid),
        .issue        (issue)
    );

    rename_table rename_table_0 (
        .clock    (clock),
        .rst      (rst),
        .src_idx  (src_idx),
        .map_we   (map_we),
        .map_rd   (map_rd),
        .map_tag  (map_tag),
        .wb       (wb),
        .src_tag  (src_tag),
        .src_ready(src_ready),
        .old_tag  (old_tag)
    );

    free_list free_list_0 (
        .clock     (clock),
        .rst       (rst),
        .alloc     (fl_alloc),
        .free_valid(free_valid),
        .free_tag  (free_tag),
        .avail     (fl_avail),
        .alloc_tag (fl_tag)
    );

    //////////////////////////////////////////////////////////////////////
    // Execute and retire
    phys_regfile phys_regfile_0 (
        .clock  (clock),
        .rst    (rst),
        .rd_tag (rd_tag),
        .wb     (wb),
        .rd_data(rd_data)
    );

    alu_pipe alu_pipe_0 (
        .clock      (clock),
        .rst        (rst),
        .issue_valid(issue_valid),
        .issue      (issue),
        .wb         (wb)
    );

    reorder_buffer reorder_buffer_0 (
        .clock     (clock),
        .rst       (rst),
        .push      (rob_push),
        .entry     (rob_entry),
        .wb        (wb),
        .full      (rob_full),
        .slot      (rob_slot),
        .free_valid(free_valid),
        .free_tag  (free_tag),
        .commit    (commit)
    );

endmodule

`default_nettype wire

// ==== test/ooo_core_tb.sv ====
/*
 * Testbench for the out-of-order core: credit-obeying sender driven
 * from a table, architectural reference model, commit and credit checks
 */
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb
    import ooo_pkg::*;
;

    localparam int IQ_DEPTH        = 4;
    localparam int NUM_TESTS       = 64;
    localparam int NUM_DIRECTED    = 14;
    localparam int CLK_PERIOD      = 10;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 20;

    // Stimulus with its expected commit record
    typedef struct packed {
        instr_t  instr;
        commit_t exp;
    } test_entry_t;

    logic        clock = 1'b0;
    logic        rst;
    logic        in_valid;
    instr_t      in_instr;
    logic        credit_return;
    commit_t     commit;

    test_entry_t tests [NUM_TESTS];
    data_t       model_regs [ARCH_REGS];
    int          sent;
    int          returned;
    int          commit_idx;
    int          commit_errors;
    int          credit_errors;
    int          flag_errors;

    ooo_core #(
        .IQ_DEPTH(IQ_DEPTH)
    ) dut (
        .clock        (clock),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .credit_return(credit_return),
        .commit       (commit)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers and reference model

    function automatic instr_t make_instr(input alu_op_e op, input int rd,
                                          input int rs1, input int rs2,
                                          input data_t imm);
        instr_t ins;
        ins.op  = op;
        ins.rd  = arch_idx_t'(rd);
        ins.rs1 = arch_idx_t'(rs1);
        ins.rs2 = arch_idx_t'(rs2);
        ins.imm = imm;
        return ins;
    endfunction

    function automatic instr_t random_instr();
        logic [1:0] op_bits;
        instr_t     ins;
        op_bits = 2'($urandom_range(0, 3));
        ins.op  = alu_op_e'(op_bits);
        ins.rd  = arch_idx_t'($urandom_range(0, ARCH_REGS - 1));
        ins.rs1 = arch_idx_t'($urandom_range(0, ARCH_REGS - 1));
        ins.rs2 = arch_idx_t'($urandom_range(0, ARCH_REGS - 1));
        ins.imm = data_t'($urandom);
        return ins;
    endfunction

    // Architectural result of one instruction
    function automatic data_t model_result(input instr_t ins, input data_t a,
                                           input data_t b);
        data_t v;
        case (ins.op)
            ADD:     v = a + b;
            SUB:     v = a - b;
            XOR:     v = a ^ b;
            default: v = ins.imm;
        endcase
        return v;
    endfunction

    // Walk the program in order over the eight registers
    task automatic run_model();
        data_t v;
        for (int r = 0; r < ARCH_REGS; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            v = model_result(tests[i].instr, model_regs[tests[i].instr.rs1],
                             model_regs[tests[i].instr.rs2]);
            model_regs[tests[i].instr.rd] = v;
            tests[i].exp.valid = 1'b1;
            tests[i].exp.rd    = tests[i].instr.rd;
            tests[i].exp.value = v;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_commit(input commit_t got, input commit_t exp, input int idx);
        if (got.rd !== exp.rd || got.value !== exp.value) begin
            $display("FAIL %0t: commit %0d rd=%0d value=%h, expected rd=%0d value=%h",
                     $time, idx, got.rd, got.value, exp.rd, exp.value);
            commit_errors++;
        end
    endtask

    task automatic check_credit(input string what, input int got, input int lo,
                                input int hi);
        if (got < lo || got > hi) begin
            $display("FAIL %0t: %s is %0d, expected %0d to %0d", $time, what, got, lo, hi);
            credit_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            flag_errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor, sampled mid-cycle
    always @(negedge clock) begin
        if (!rst) begin
            // Quiet outputs until the first send
            if (sent == 0) begin
                check_flag("credit_return before first send", credit_return, 1'b0);
                check_flag("commit.valid before first send", commit.valid, 1'b0);
            end
            if (credit_return === 1'b1) begin
                returned++;
            end
            if (commit.valid === 1'b1) begin
                if (commit_idx >= NUM_TESTS) begin
                    $display("Unexpected extra commit at time %0t after all %0d instructions",
                             $time, NUM_TESTS);
                    commit_errors++;
                end else begin
                    check_commit(commit, tests[commit_idx].exp, commit_idx);
                    commit_idx++;
                end
            end
        end
    end

    // Hang guard
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles with %0d of %0d instructions committed",
                 WATCHDOG_CYCLES, commit_idx, NUM_TESTS);
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        int i;
        int gap;
        int credits;

        rst           = 1'b1;
        in_valid      = 1'b0;
        in_instr      = '0;
        sent          = 0;
        returned      = 0;
        commit_idx    = 0;
        commit_errors = 0;
        credit_errors = 0;
        flag_errors   = 0;
        void'($urandom(45205));

        // Directed head of the program
        tests[0].instr  = make_instr(LI, 1, 0, 0, 16'h0005);
        tests[1].instr  = make_instr(LI, 2, 0, 0, 16'h0007);
        tests[2].instr  = make_instr(ADD, 3, 1, 2, 16'h0000);
        tests[3].instr  = make_instr(ADD, 3, 3, 3, 16'h0000);
        tests[4].instr  = make_instr(SUB, 4, 3, 1, 16'h0000);
        tests[5].instr  = make_instr(XOR, 5, 4, 2, 16'h0000);
        // Repeated writes to r1
        tests[6].instr  = make_instr(LI, 1, 0, 0, 16'h1234);
        tests[7].instr  = make_instr(LI, 1, 0, 0, 16'hffff);
        tests[8].instr  = make_instr(ADD, 1, 1, 1, 16'h0000);
        tests[9].instr  = make_instr(ADD, 1, 1, 2, 16'h0000);
        tests[10].instr = make_instr(SUB, 0, 0, 1, 16'h0000);
        tests[11].instr = make_instr(XOR, 6, 1, 1, 16'h0000);
        tests[12].instr = make_instr(ADD, 7, 0, 5, 16'h0000);
        tests[13].instr = make_instr(SUB, 7, 7, 7, 16'h0000);
        for (int k = NUM_DIRECTED; k < NUM_TESTS; k++) begin
            tests[k].instr = random_instr();
        end
        run_model();

        repeat (4) @(posedge clock);
        rst <= 1'b0;

        // First half with random idle cycles, second half back to back
        i   = 0;
        gap = 2;
        while (i < NUM_TESTS) begin
            @(posedge clock);
            credits = IQ_DEPTH - sent + returned;
            check_credit("sender credit count", credits, 0, IQ_DEPTH);
            if (gap > 0) begin
                gap--;
                in_valid <= 1'b0;
            end else if (credits > 0) begin
                in_valid <= 1'b1;
                in_instr <= tests[i].instr;
                sent++;
                i++;
                if (i < NUM_TESTS / 2) begin
                    gap = $urandom_range(0, 2);
                end
            end else begin
                in_valid <= 1'b0;
            end
        end
        @(posedge clock);
        in_valid <= 1'b0;

        // Every commit follows its dispatch, so all credits are back by now
        wait (commit_idx == NUM_TESTS);
        // Room for any stray commit or credit
        repeat (6) @(posedge clock);

        check_credit("credits returned", returned, sent, sent);
        check_credit("final credit count", IQ_DEPTH - sent + returned, IQ_DEPTH, IQ_DEPTH);

        $display("Errors: commit %0d, credit %0d, flag %0d",
                 commit_errors, credit_errors, flag_errors);
        if (commit_errors + credit_errors + flag_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
design/ooo_pkg.sv
design/ring_queue.sv
design/rename_table.sv
design/free_list.sv
design/reorder_buffer.sv
design/phys_regfile.sv
design/alu_pipe.sv
design/dispatch_ctrl.sv
design/ooo_core.sv
test/ooo_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    -f compile.f --top-module ooo_core_tb \
    -Mdir "$BUILD_DIR" -o ooo_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/ooo_core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0
